// File: dv/scratchpad_stim.txt
# columns: test kind opcode addr data expected, test and kind decimal, the rest hex
# kind 0 is a command, 1 a peek; opcode 0 write, 1 read, 2 add
1 0 0 10 1234 1234
1 0 0 11 abcd abcd
1 0 0 12 0001 0001
1 0 0 fe 5a5a 5a5a
1 0 1 10 0000 1234
1 0 1 12 0000 0001
1 0 1 11 0000 abcd
1 0 1 fe 0000 5a5a
1 0 0 10 beef beef
1 0 1 10 0000 beef
2 0 0 20 0000 0000
2 0 2 20 0005 0005
2 0 2 20 0010 0015
2 0 2 20 0100 0115
2 0 1 20 0000 0115
2 0 0 21 fff0 fff0
2 0 2 21 0008 fff8
2 0 2 21 0010 0008
2 0 2 21 ffff 0007
2 0 1 21 0000 0007
2 1 0 20 0000 0115
2 1 0 21 0000 0007
3 0 0 30 1000 1000
3 0 2 30 0001 1001
3 0 1 30 0000 1001
3 0 0 31 2000 2000
3 0 0 32 3000 3000
3 0 2 31 0002 2002
3 0 2 32 0003 3003
3 0 2 32 0004 3007
3 0 1 31 0000 2002
3 0 0 30 0000 0000
3 0 2 30 ffff ffff
3 0 2 30 0001 0000
3 0 1 30 0000 0000
3 1 0 32 0000 3007
4 0 0 40 0100 0100
4 0 2 40 0001 0101
4 0 2 40 0002 0103
4 0 0 41 7777 7777
4 0 2 41 1111 8888
4 0 1 40 0000 0103
4 0 2 40 fefd 0000
4 0 1 41 0000 8888
4 0 0 42 00aa 00aa
4 0 2 42 00aa 0154
4 0 2 41 0001 8889
4 0 1 42 0000 0154
4 0 1 40 0000 0000
4 1 0 41 0000 8889
5 0 0 50 cafe cafe
5 0 0 51 0f0f 0f0f
5 1 0 50 0000 cafe
5 1 0 51 0000 0f0f
5 1 0 10 0000 beef
5 1 0 fe 0000 5a5a
5 0 2 50 0001 caff
5 1 0 50 0000 caff

// File: sources.f
common/scratch_pkg.sv
ram_2port/ram_2port.sv
rtl/cmd_decode.sv
rtl/accum_stage.sv
rtl/resp_stage.sv
rtl/scratchpad_top.sv
dv/scratchpad_tb.sv

// File: Makefile
# Verilator flow for the accumulating scratchpad.

TB_TOP = scratchpad_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module scratchpad_top \
		common/scratch_pkg.sv ram_2port/ram_2port.sv rtl/cmd_decode.sv \
		rtl/accum_stage.sv rtl/resp_stage.sv rtl/scratchpad_top.sv

sim:
	verilator --binary --timing --top-module $(TB_TOP) -f sources.f -o $(TB_TOP)
	./obj_dir/$(TB_TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then echo "no result in sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: dv/scratchpad_tb.sv
// testbench for the accumulating scratchpad
// replays commands and peeks from the stimulus file and checks every
// response in order, with random back-pressure in one test.

`timescale 1ns/1ps

module scratchpad_tb
	import scratch_pkg::*;
();

	localparam int MAX_LINES = 256;
	localparam int BP_TEST = 4;
	localparam int RESET_CYCLES = 10;

	logic                clock;
	logic                rst_n;
	cmd_t                cmd;
	logic                cmd_valid;
	logic                cmd_ready;
	resp_t               resp;
	logic                resp_valid;
	logic                resp_ready;
	logic [ADDR_W-1 : 0] peek_addr;
	logic [WORD_W-1 : 0] peek_data;

	// stimulus lines as read from the file.
	int                  st_test [MAX_LINES];
	int                  st_kind [MAX_LINES];
	logic [1:0]          st_op   [MAX_LINES];
	logic [ADDR_W-1 : 0] st_addr [MAX_LINES];
	logic [WORD_W-1 : 0] st_data [MAX_LINES];
	logic [WORD_W-1 : 0] st_exp  [MAX_LINES];
	int                  n_lines;
	bit                  stim_loaded;

	// expected responses that the driver writes and the monitor reads.
	resp_t               exp_list [MAX_LINES];
	int                  exp_wr;
	int                  exp_rd;

	bit                  bp_mode;
	logic [31:0]         rng_state;
	int                  checks;
	int                  errors;
	int                  resp_checks;
	int                  resp_errors;
	int                  tests_run;
	int                  cycle_count;
	int                  cycle_limit;

	scratchpad_top u_dut (
		.clock(clock), .rst_n(rst_n),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
		.peek_addr(peek_addr), .peek_data(peek_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int total_checks();
		return checks + resp_checks;
	endfunction

	function automatic int total_errors();
		return errors + resp_errors;
	endfunction

	// the receiver is ready about five cycles in eight under back-pressure.
	initial begin
		resp_ready = 1'b1;
		rng_state = 32'hdb4b;
		forever begin
			@(negedge clock);
			if (bp_mode) begin
				rng_state = xorshift32(rng_state);
				resp_ready = (rng_state[2:0] > 3'd2);
			end else begin
				resp_ready = 1'b1;
			end
		end
	end

	// each response transfer is compared with the oldest expected one.
	initial begin
		resp_checks = 0;
		resp_errors = 0;
		exp_rd = 0;
		forever begin
			@(posedge clock);
			if (rst_n && resp_valid && resp_ready) begin
				if (exp_rd == exp_wr) begin
					$display("response for address %h arrived with no command outstanding",
						resp.addr);
					resp_errors++;
				end else begin
					resp_checks++;
					if (resp.addr !== exp_list[exp_rd].addr) begin
						$display("ERROR resp.addr: got %h, expected %h",
							resp.addr, exp_list[exp_rd].addr);
						resp_errors++;
					end
					if (resp.data !== exp_list[exp_rd].data) begin
						$display("ERROR resp.data at address %h: got %h, expected %h",
							exp_list[exp_rd].addr, resp.data, exp_list[exp_rd].data);
						resp_errors++;
					end
					exp_rd++;
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		wait (stim_loaded);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles, %0d responses missing",
			cycle_count, exp_wr - exp_rd);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic load_stimulus(output bit ok);
		int                  fd;
		int                  n;
		int                  rd_test;
		int                  rd_kind;
		logic [1:0]          rd_op;
		logic [ADDR_W-1 : 0] rd_addr;
		logic [WORD_W-1 : 0] rd_data;
		logic [WORD_W-1 : 0] rd_exp;
		logic [8*128-1 : 0]  skip_buf;
		bit                  done;
		bit                  bad_line;
		n_lines = 0;
		done = 1'b0;
		bad_line = 1'b0;
		fd = $fopen("dv/scratchpad_stim.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
		end else begin
			while (!done && !$feof(fd) && n_lines < MAX_LINES) begin
				n = $fscanf(fd, "%d %d %h %h %h %h\n",
					rd_test, rd_kind, rd_op, rd_addr, rd_data, rd_exp);
				if (n == 6) begin
					st_test[n_lines] = rd_test;
					st_kind[n_lines] = rd_kind;
					st_op[n_lines] = rd_op;
					st_addr[n_lines] = rd_addr;
					st_data[n_lines] = rd_data;
					st_exp[n_lines] = rd_exp;
					n_lines++;
				end else if (n > 0) begin
					// a data line that holds fewer than six fields.
					bad_line = 1'b1;
					done = 1'b1;
				end else if ($fgets(skip_buf, fd) == 0) begin
					// nothing left to read.
					done = 1'b1;
				end
			end
			$fclose(fd);
			ok = (n_lines > 0) && !bad_line;
		end
	endtask

	task automatic check_idle_outputs(input string phase);
		checks += 2;
		if (resp_valid !== 1'b0) begin
			$display("ERROR resp_valid %s: got %h, expected 0", phase, resp_valid);
			errors++;
		end
		if (cmd_ready !== 1'b1) begin
			$display("ERROR cmd_ready %s: got %h, expected 1", phase, cmd_ready);
			errors++;
		end
	endtask

	task automatic check_reset();
		int errors_before;
		errors_before = total_errors();
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_idle_outputs("during reset");
		end
		rst_n = 1'b1;
		@(negedge clock);
		check_idle_outputs("after reset");
		tests_run++;
		$display("test reset done: %0d errors", total_errors() - errors_before);
	endtask

	task automatic set_backpressure(input bit on);
		@(posedge clock);
		bp_mode = on;
		@(negedge clock);
	endtask

	// drives one command and holds it until the DUT takes it.
	task automatic issue_cmd(input int idx);
		bit accepted;
		cmd.op = opcode_e'(st_op[idx]);
		cmd.addr = st_addr[idx];
		cmd.data = st_data[idx];
		cmd_valid = 1'b1;
		exp_list[exp_wr].addr = st_addr[idx];
		exp_list[exp_wr].data = st_exp[idx];
		exp_wr++;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clock);
			accepted = cmd_ready;
		end
		@(negedge clock);
	endtask

	task automatic drain_responses();
		while (exp_rd != exp_wr) begin
			@(negedge clock);
		end
	endtask

	// peek only after all earlier responses left and two idle cycles.
	task automatic check_peek(input int idx);
		cmd_valid = 1'b0;
		drain_responses();
		repeat (2) @(negedge clock);
		peek_addr = st_addr[idx];
		@(negedge clock);
		checks++;
		if (peek_data !== st_exp[idx]) begin
			$display("ERROR peek_data at address %h: got %h, expected %h",
				st_addr[idx], peek_data, st_exp[idx]);
			errors++;
		end
	endtask

	task automatic run_test(input int first, output int next);
		int idx;
		int test_id;
		int checks_before;
		int errors_before;
		idx = first;
		test_id = st_test[first];
		checks_before = total_checks();
		errors_before = total_errors();
		if (test_id == BP_TEST) begin
			set_backpressure(1'b1);
		end
		while (idx < n_lines && st_test[idx] == test_id) begin
			if (st_kind[idx] == 1) begin
				check_peek(idx);
			end else begin
				issue_cmd(idx);
			end
			idx++;
		end
		cmd_valid = 1'b0;
		drain_responses();
		if (test_id == BP_TEST) begin
			set_backpressure(1'b0);
		end
		tests_run++;
		$display("test %0d done: %0d checks, %0d errors", test_id,
			total_checks() - checks_before, total_errors() - errors_before);
		next = idx;
	endtask

	initial begin
		int idx;
		bit load_ok;
		rst_n = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;
		peek_addr = '0;
		bp_mode = 1'b0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		exp_wr = 0;
		load_stimulus(load_ok);
		if (!load_ok) begin
			$display("stimulus file dv/scratchpad_stim.txt is missing, empty or malformed");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			cycle_limit = 20 * n_lines + 100;
			stim_loaded = 1'b1;
			check_reset();
			idx = 0;
			while (idx < n_lines) begin
				run_test(idx, idx);
			end
			$display("summary: %0d tests, %0d checks, %0d errors",
				tests_run, total_checks(), total_errors());
			if (total_errors() == 0 && total_checks() > 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

// File: rtl/scratchpad_top.sv
// accumulating scratchpad, top level
// three-stage write/read/add pipeline around a two-port ram,
// with a direct read-only peek port on ram port 2.

`timescale 1ns/1ps

module scratchpad_top
	import scratch_pkg::*;
#(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 16
) (
	input  logic                   clock,
	input  logic                   rst_n,

	// command channel
	input  cmd_t                   cmd,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,

	// response channel
	output resp_t                  resp,
	output logic                   resp_valid,
	input  logic                   resp_ready,

	// peek port, one cycle latency
	input  logic [ADDR_BITS-1 : 0] peek_addr,
	output logic [WORD_BITS-1 : 0] peek_data
);

	logic                   stall;

	cmd_t                   s1_cmd;
	logic                   s1_valid;
	resp_t                  s2_resp;
	logic                   s2_valid;

	// ram port 1
	logic [ADDR_BITS-1 : 0] ram_addr;
	logic                   ram_read_ena;
	logic [WORD_BITS-1 : 0] ram_data;
	logic                   write_ena;
	logic [ADDR_BITS-1 : 0] write_addr;
	logic [WORD_BITS-1 : 0] write_data;

	cmd_decode #(.ADDR_BITS(ADDR_BITS)) u_cmd_decode (
		.clock(clock), .rst_n(rst_n),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .stall(stall),
		.s1_cmd(s1_cmd), .s1_valid(s1_valid),
		.ram_addr(ram_addr), .ram_read_ena(ram_read_ena)
	);

	accum_stage #(.ADDR_BITS(ADDR_BITS), .WORD_BITS(WORD_BITS)) u_accum_stage (
		.clock(clock), .rst_n(rst_n),
		.s1_cmd(s1_cmd), .s1_valid(s1_valid), .stall(stall),
		.ram_data(ram_data),
		.write_ena(write_ena), .write_addr(write_addr), .write_data(write_data),
		.s2_resp(s2_resp), .s2_valid(s2_valid)
	);

	resp_stage u_resp_stage (
		.clock(clock), .rst_n(rst_n),
		.s2_resp(s2_resp), .s2_valid(s2_valid),
		.resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
		.stall(stall)
	);

	// port 1 belongs to the pipeline, port 2 to the peek port.
	ram_2port #(.ADDR_BITS(ADDR_BITS), .WORD_BITS(WORD_BITS)) u_ram (
		.clock(clock), .rst_n(rst_n),
		.read_ena_1(ram_read_ena), .write_ena_1(write_ena),
		.addr_1(ram_addr), .write_addr_1(write_addr),
		.data_1(write_data), .out_data_1(ram_data),
		.addr_2(peek_addr), .out_data_2(peek_data)
	);

endmodule

// File: rtl/resp_stage.sv
// stage 3, response register
// one-entry output buffer; holds the response until the receiver
// takes it and stalls the pipeline behind it meanwhile.

`timescale 1ns/1ps

module resp_stage
	import scratch_pkg::*;
(
	input  logic  clock,
	input  logic  rst_n,

	// from stage 2
	input  resp_t s2_resp,
	input  logic  s2_valid,

	// response channel
	output resp_t resp,
	output logic  resp_valid,
	input  logic  resp_ready,

	// freezes stages 1 and 2
	output logic  stall
);

	logic load;

	// a held response that is not taken blocks everything upstream.
	assign stall = resp_valid & ~resp_ready;

	// empty or being drained this cycle.
	assign load = ~stall;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else if (load) begin
			resp_valid <= s2_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (load && s2_valid) begin
			resp <= s2_resp;
		end
	end

endmodule

// File: rtl/accum_stage.sv
// stage 2, accumulate and write back
// picks the old word from the ram or from the previous write,
// computes the new value, writes it to the ram and registers the response.

`timescale 1ns/1ps

module accum_stage
	import scratch_pkg::*;
#(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 16
) (
	input  logic                   clock,
	input  logic                   rst_n,

	// from stage 1
	input  cmd_t                   s1_cmd,
	input  logic                   s1_valid,
	input  logic                   stall,

	// ram port 1
	input  logic [WORD_BITS-1 : 0] ram_data,
	output logic                   write_ena,
	output logic [ADDR_BITS-1 : 0] write_addr,
	output logic [WORD_BITS-1 : 0] write_data,

	// to stage 3
	output resp_t                  s2_resp,
	output logic                   s2_valid
);

	// record of the last write.
	logic                   fwd_valid;
	logic [ADDR_BITS-1 : 0] fwd_addr;
	logic [WORD_BITS-1 : 0] fwd_data;

	logic                   fwd_hit;
	logic                   is_write_op;
	logic [WORD_BITS-1 : 0] old_word;
	logic [WORD_BITS-1 : 0] new_word;

	// the ram read for this command was issued at the edge of that write,
	// so it still carries the stale word.
	assign fwd_hit = fwd_valid && (fwd_addr == s1_cmd.addr);
	assign old_word = fwd_hit ? fwd_data : ram_data;

	always_comb begin
		case (s1_cmd.op)
			OP_WRITE: new_word = s1_cmd.data;
			// wraps around at WORD_BITS.
			OP_ADD:   new_word = old_word + s1_cmd.data;
			default:  new_word = old_word;
		endcase
	end

	assign is_write_op = (s1_cmd.op == OP_WRITE) || (s1_cmd.op == OP_ADD);

	// ram write at the same edge that registers the response.
	assign write_ena = s1_valid & is_write_op & ~stall;
	assign write_addr = s1_cmd.addr;
	assign write_data = new_word;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid  <= 1'b0;
			fwd_valid <= 1'b0;
		end else if (!stall) begin
			s2_valid  <= s1_valid;
			fwd_valid <= write_ena;
		end
	end

	always_ff @(posedge clock) begin
		if (write_ena) begin
			fwd_addr <= write_addr;
			fwd_data <= write_data;
		end
	end

	always_ff @(posedge clock) begin
		if (s1_valid && !stall) begin
			s2_resp.addr <= s1_cmd.addr;
			s2_resp.data <= new_word;
		end
	end

endmodule

// File: rtl/cmd_decode.sv
// stage 1, command decode
// accepts commands, registers them and issues the ram read
// so the old word arrives together with stage 2's turn.

`timescale 1ns/1ps

module cmd_decode
	import scratch_pkg::*;
#(
	parameter int ADDR_BITS = 8
) (
	input  logic                   clock,
	input  logic                   rst_n,

	// command channel
	input  cmd_t                   cmd,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	input  logic                   stall,

	// to stage 2
	output cmd_t                   s1_cmd,
	output logic                   s1_valid,

	// ram port 1 read
	output logic [ADDR_BITS-1 : 0] ram_addr,
	output logic                   ram_read_ena
);

	logic accept;

	// a response leaving frees the pipeline in the same cycle.
	assign cmd_ready = ~stall;
	assign accept = cmd_valid & ~stall;

	// read with the incoming address, data lands as the command reaches stage 2.
	assign ram_addr = cmd.addr;
	assign ram_read_ena = accept;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else if (!stall) begin
			s1_valid <= cmd_valid;
		end
	end

	// payload only moves with an accepted command.
	always_ff @(posedge clock) begin
		if (accept) begin
			s1_cmd <= cmd;
		end
	end

endmodule

// File: ram_2port/ram_2port.sv
// dual-port ram
// port 1 reads and writes, port 2 only reads.
// both reads are registered; port 1's output holds while its read enable is low.

`timescale 1ns/1ps

module ram_2port #(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 16
) (
	input  logic                   clock,
	input  logic                   rst_n,

	// port 1, read and write
	input  logic                   read_ena_1,
	input  logic                   write_ena_1,
	input  logic [ADDR_BITS-1 : 0] addr_1,
	input  logic [ADDR_BITS-1 : 0] write_addr_1,
	input  logic [WORD_BITS-1 : 0] data_1,
	output logic [WORD_BITS-1 : 0] out_data_1,

	// port 2, read only
	input  logic [ADDR_BITS-1 : 0] addr_2,
	output logic [WORD_BITS-1 : 0] out_data_2
);

	localparam int NUM_WORDS = 2 ** ADDR_BITS;

	logic [WORD_BITS-1 : 0] words [NUM_WORDS];

	// write port; the array itself has no reset.
	always_ff @(posedge clock) begin
		if (write_ena_1) begin
			words[write_addr_1] <= data_1;
		end
	end

	// port 1 read, returns the old word on a same-edge write.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_data_1 <= '0;
		end else if (read_ena_1) begin
			out_data_1 <= words[addr_1];
		end
	end

	// port 2 reads every cycle.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_data_2 <= '0;
		end else begin
			out_data_2 <= words[addr_2];
		end
	end

endmodule

// File: common/scratch_pkg.sv
// scratchpad shared types
// opcodes plus the command and response words that travel
// through the accumulating scratchpad pipeline.

package scratch_pkg;

	// default field widths of the command and response words.
	localparam int ADDR_W = 8;
	localparam int WORD_W = 16;

	// command opcodes.
	typedef enum logic [1:0] {
		OP_WRITE = 2'd0,
		OP_READ  = 2'd1,
		OP_ADD   = 2'd2
	} opcode_e;

	// command on the input channel and inside stage 1.
	typedef struct packed {
		opcode_e             op;
		logic [ADDR_W-1 : 0] addr;
		logic [WORD_W-1 : 0] data;
	} cmd_t;

	// response, the word's value after the command.
	typedef struct packed {
		logic [ADDR_W-1 : 0] addr;
		logic [WORD_W-1 : 0] data;
	} resp_t;

endpackage
